// File: logic/memcpy_pkg.sv
`default_nettype none
// ====================
// Shared widths, register map and bus structs of the copy engine
// Line count and tags are 16 bits, so one run moves at most 65535 lines
// MMIO offsets count 32-bit words, 64-bit registers sit on even offsets
// All strobes are single-cycle valids with no ready
// ====================
package memcpy_pkg;

    // ====================
    // Widths
    localparam int CL_ADDR_W   = 42;
    localparam int CL_DATA_W   = 512;
    localparam int MMIO_DATA_W = 64;
    localparam int MMIO_ADDR_W = 16;
    localparam int LINE_IDX_W  = 16;
    localparam int CNT_W       = 64;

    // ====================
    // Register map, byte offset shifted down to 32-bit units
    localparam logic [MMIO_ADDR_W-1:0] CSR_DFH          = 16'h0000;
    localparam logic [MMIO_ADDR_W-1:0] CSR_ID_L         = 16'h0002;
    localparam logic [MMIO_ADDR_W-1:0] CSR_ID_H         = 16'h0004;
    localparam logic [MMIO_ADDR_W-1:0] CSR_STATUS_ADDR  = 16'h0018 >> 2;
    localparam logic [MMIO_ADDR_W-1:0] CSR_SRC_ADDR     = 16'h0020 >> 2;
    localparam logic [MMIO_ADDR_W-1:0] CSR_DST_ADDR     = 16'h0028 >> 2;
    localparam logic [MMIO_ADDR_W-1:0] CSR_NUM_LINES    = 16'h0030 >> 2;
    localparam logic [MMIO_ADDR_W-1:0] CSR_CTL          = 16'h0070 >> 2;
    localparam logic [MMIO_ADDR_W-1:0] CSR_WR_THRESHOLD = 16'h0078 >> 2;

    localparam logic [127:0] AFU_ID = 128'h4b1f_9d3e_62a0_4c57_8e15_d0c2_7a93_f648;
    // Type AFU in bits 63:60, end of list in bit 40
    localparam logic [MMIO_DATA_W-1:0] DFH_VALUE = 64'h1000_0100_0000_0000;
    localparam logic [LINE_IDX_W-1:0] DEFAULT_WR_THRESHOLD = 16'd64;
    // Response type of a read line completion
    localparam logic [3:0] RSP_RDLINE = 4'h0;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        REPORT = 2'd2
    } copy_state_t;

    // ====================
    // Receive header, one word with two meanings
    typedef struct packed {
        logic [MMIO_ADDR_W-1:0] address;
        logic [1:0]             length;
        logic                   rsvd;
        logic [8:0]             tid;
    } mmio_req_hdr_t;

    typedef struct packed {
        logic [7:0]            rsvd;
        logic [3:0]            resp_type;
        logic [LINE_IDX_W-1:0] mdata;
    } mem_rsp_hdr_t;

    typedef union packed {
        mmio_req_hdr_t mmio;
        mem_rsp_hdr_t  rsp;
    } rx_hdr_u;

    typedef struct packed {
        logic                 mmio_rd;
        logic                 mmio_wr;
        logic                 rsp_valid;
        rx_hdr_u              hdr;
        logic [CL_DATA_W-1:0] data;
    } rx_c0_t;

    typedef struct packed {
        logic                  valid;
        logic [LINE_IDX_W-1:0] tag;
    } rx_c1_t;

    // Transmit side
    typedef struct packed {
        logic                  valid;
        logic [CL_ADDR_W-1:0]  addr;
        logic [LINE_IDX_W-1:0] tag;
    } rd_req_t;

    typedef struct packed {
        logic                  valid;
        logic [CL_ADDR_W-1:0]  addr;
        logic [LINE_IDX_W-1:0] tag;
        logic [CL_DATA_W-1:0]  data;
    } wr_req_t;

    typedef struct packed {
        logic                   valid;
        logic [8:0]             tid;
        logic [MMIO_DATA_W-1:0] data;
    } mmio_rsp_t;

    // Between the stages
    typedef struct packed {
        logic [CL_ADDR_W-1:0]  status_addr;
        logic [CL_ADDR_W-1:0]  src_addr;
        logic [CL_ADDR_W-1:0]  dst_addr;
        logic [LINE_IDX_W-1:0] num_lines;
        logic [LINE_IDX_W-1:0] wr_threshold;
    } copy_cfg_t;

    typedef struct packed {
        logic                  valid;
        logic [CNT_W-1:0]      cycles;
        logic [LINE_IDX_W-1:0] lines_read;
        logic [LINE_IDX_W-1:0] wr_rsp;
    } copy_report_t;

endpackage
`default_nettype wire

// File: logic/mmio_csr.sv
`timescale 1ns/1ns
`default_nettype none
// ====================
// MMIO register block of the copy engine
// Reads answer one cycle after the strobe, unknown offsets read as 0
// Writes land one cycle after the strobe
// A start write is dropped unless source, destination and count are nonzero
// ====================
module mmio_csr
    import memcpy_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  rx_c0_t    rx_c0,
    output mmio_rsp_t mmio_rsp,
    output copy_cfg_t cfg,
    output logic      start
);

    mmio_req_hdr_t          req;
    logic [MMIO_DATA_W-1:0] rd_data;
    logic                   cfg_ok;

    // Shared header seen as an MMIO request
    assign req = rx_c0.hdr.mmio;

    // Start only makes sense with a full configuration
    assign cfg_ok = (cfg.src_addr != '0) && (cfg.dst_addr != '0) &&
                    (cfg.num_lines != '0);

    // ====================
    // Read path
    always_comb
    begin
        case (req.address)
            CSR_DFH:          rd_data = DFH_VALUE;
            CSR_ID_L:         rd_data = AFU_ID[63:0];
            CSR_ID_H:         rd_data = AFU_ID[127:64];
            CSR_STATUS_ADDR:  rd_data = MMIO_DATA_W'(cfg.status_addr);
            CSR_SRC_ADDR:     rd_data = MMIO_DATA_W'(cfg.src_addr);
            CSR_DST_ADDR:     rd_data = MMIO_DATA_W'(cfg.dst_addr);
            CSR_NUM_LINES:    rd_data = MMIO_DATA_W'(cfg.num_lines);
            CSR_WR_THRESHOLD: rd_data = MMIO_DATA_W'(cfg.wr_threshold);
            // CTL is write-only and reads back 0
            default:          rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mmio_rsp.valid <= 1'b0;
        end
        else
        begin
            // Every read gets exactly one response
            mmio_rsp.valid <= rx_c0.mmio_rd;
        end
    end

    // Tag and data follow the request
    always_ff @(posedge clk)
    begin
        mmio_rsp.tid  <= req.tid;
        mmio_rsp.data <= rd_data;
    end

    // ====================
    // Write path
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg.status_addr  <= '0;
            cfg.src_addr     <= '0;
            cfg.dst_addr     <= '0;
            cfg.num_lines    <= '0;
            cfg.wr_threshold <= DEFAULT_WR_THRESHOLD;
            start            <= 1'b0;
        end
        else
        begin
            // Start is a single-cycle pulse
            start <= 1'b0;
            if (rx_c0.mmio_wr)
            begin
                case (req.address)
                    CSR_STATUS_ADDR:  cfg.status_addr  <= rx_c0.data[CL_ADDR_W-1:0];
                    CSR_SRC_ADDR:     cfg.src_addr     <= rx_c0.data[CL_ADDR_W-1:0];
                    CSR_DST_ADDR:     cfg.dst_addr     <= rx_c0.data[CL_ADDR_W-1:0];
                    CSR_NUM_LINES:    cfg.num_lines    <= rx_c0.data[LINE_IDX_W-1:0];
                    CSR_WR_THRESHOLD: cfg.wr_threshold <= rx_c0.data[LINE_IDX_W-1:0];
                    CSR_CTL:          start            <= rx_c0.data[0] && cfg_ok;
                    default:          start            <= 1'b0;
                endcase
            end
        end
    end

endmodule
`default_nettype wire

// File: logic/copy_control.sv
`timescale 1ns/1ns
`default_nettype none
// ====================
// Copy sequencer, IDLE then RUN then one REPORT cycle
// In-flight check is two registers deep, so up to threshold plus 2
// lines may be outstanding
// Reads stop at most 3 cycles after almost-full rises
// ====================
module copy_control
    import memcpy_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  copy_cfg_t    cfg,
    input  logic         start,
    input  logic         tx_almost_full,
    input  rx_c1_t       rx_c1,
    output rd_req_t      rd_req,
    output copy_report_t report
);

    copy_state_t           state;
    logic [LINE_IDX_W-1:0] rd_idx;
    logic [LINE_IDX_W-1:0] wr_rsp_cnt;
    logic [CNT_W-1:0]      cycle_cnt;
    // Throttle pipeline
    logic                  chk_valid;
    logic [LINE_IDX_W-1:0] issued_q;
    logic [LINE_IDX_W:0]   limit_q;
    logic                  can_read;
    logic                  issue;
    logic                  rd_done;

    assign rd_done = (rd_idx == cfg.num_lines);
    assign issue   = (state == RUN) && can_read && !rd_done;

    // ====================
    // State machine and counters
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= IDLE;
            rd_idx     <= '0;
            wr_rsp_cnt <= '0;
            cycle_cnt  <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (start)
                    begin
                        state      <= RUN;
                        rd_idx     <= '0;
                        wr_rsp_cnt <= '0;
                        cycle_cnt  <= '0;
                    end
                RUN:
                begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (issue)
                        rd_idx <= rd_idx + 1'b1;
                    if (rx_c1.valid)
                        wr_rsp_cnt <= wr_rsp_cnt + 1'b1;
                    // Done once every line is out and written back
                    if (rd_done && wr_rsp_cnt == cfg.num_lines)
                        state <= REPORT;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // ====================
    // Throttle, stage 1 samples, stage 2 compares
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            chk_valid <= 1'b0;
            can_read  <= 1'b0;
        end
        else
        begin
            chk_valid <= (state == RUN) && !tx_almost_full;
            can_read  <= chk_valid && ({1'b0, issued_q} < limit_q);
        end
    end

    // issued - responses < threshold, rearranged to avoid a subtract
    always_ff @(posedge clk)
    begin
        issued_q <= rd_idx;
        limit_q  <= {1'b0, wr_rsp_cnt} + {1'b0, cfg.wr_threshold};
    end

    // ====================
    // Read request, tagged with its line index
    always_ff @(posedge clk)
    begin
        if (reset)
            rd_req.valid <= 1'b0;
        else
            rd_req.valid <= issue;
    end

    always_ff @(posedge clk)
    begin
        rd_req.addr <= cfg.src_addr + CL_ADDR_W'(rd_idx);
        rd_req.tag  <= rd_idx;
    end

    // Status fields, valid for the single REPORT cycle
    assign report.valid      = (state == REPORT);
    assign report.cycles     = cycle_cnt;
    assign report.lines_read = rd_idx;
    assign report.wr_rsp     = wr_rsp_cnt;

endmodule
`default_nettype wire

// File: logic/line_writer.sv
`timescale 1ns/1ns
`default_nettype none
// ====================
// Write side of the copy engine
// Each read response becomes one line write on the next cycle
// Destination line is dst plus the returned tag, so order does not matter
// Status line goes out one cycle after the report strobe
// ====================
module line_writer
    import memcpy_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  rx_c0_t       rx_c0,
    input  copy_cfg_t    cfg,
    input  copy_report_t report,
    output wr_req_t      wr_req
);

    mem_rsp_hdr_t         rsp;
    logic                 rsp_hit;
    logic [CL_DATA_W-1:0] status_line;

    // Shared header seen as a memory response
    assign rsp     = rx_c0.hdr.rsp;
    assign rsp_hit = rx_c0.rsp_valid && (rsp.resp_type == RSP_RDLINE);

    // ====================
    // Status line layout
    always_comb
    begin
        status_line          = '0;
        // Completion flag
        status_line[0]       = 1'b1;
        status_line[127:64]  = report.cycles;
        status_line[159:128] = 32'(report.lines_read);
        status_line[191:160] = 32'(report.wr_rsp);
    end

    // ====================
    // Write request
    always_ff @(posedge clk)
    begin
        if (reset)
            wr_req.valid <= 1'b0;
        else
            wr_req.valid <= rsp_hit || report.valid;
    end

    // Response data wins, the report only comes after the last response
    always_ff @(posedge clk)
    begin
        if (rsp_hit)
        begin
            wr_req.addr <= cfg.dst_addr + CL_ADDR_W'(rsp.mdata);
            wr_req.tag  <= rsp.mdata;
            wr_req.data <= rx_c0.data;
        end
        else if (report.valid)
        begin
            wr_req.addr <= cfg.status_addr;
            wr_req.tag  <= '0;
            wr_req.data <= status_line;
        end
    end

endmodule
`default_nettype wire

// File: logic/memcpy.sv
`timescale 1ns/1ns
`default_nettype none
// ====================
// Memory copy engine top
// All host outputs come straight from registers
// Inputs are used as they arrive, with no input register stage
// ====================
module memcpy
    import memcpy_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  rx_c0_t    rx_c0,
    input  rx_c1_t    rx_c1,
    input  logic      tx_almost_full,
    output rd_req_t   rd_req,
    output wr_req_t   wr_req,
    output mmio_rsp_t mmio_rsp
);

    copy_cfg_t    cfg;
    logic         start;
    copy_report_t report;

    // Register block and start pulse
    mmio_csr mmio_csr_i (
        .clk      (clk),
        .reset    (reset),
        .rx_c0    (rx_c0),
        .mmio_rsp (mmio_rsp),
        .cfg      (cfg),
        .start    (start)
    );

    // Sequencer and read issue
    copy_control copy_control_i (
        .clk            (clk),
        .reset          (reset),
        .cfg            (cfg),
        .start          (start),
        .tx_almost_full (tx_almost_full),
        .rx_c1          (rx_c1),
        .rd_req         (rd_req),
        .report         (report)
    );

    // Line and status writes
    line_writer line_writer_i (
        .clk    (clk),
        .reset  (reset),
        .rx_c0  (rx_c0),
        .cfg    (cfg),
        .report (report),
        .wr_req (wr_req)
    );

endmodule
`default_nettype wire

// File: testbench/host_model.sv
`timescale 1ns/1ns
`default_nettype none
// ====================
// Host memory model for the copy engine testbench
// Read data is a pattern of the line address, answered after 1 to 8 cycles
// At most one read response and one write response per cycle
// Almost-full comes in short random bursts
// ====================
module host_model
    import memcpy_pkg::*;
#(
    parameter int SEED = 1
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  rd_req_t               rd_req,
    input  wr_req_t               wr_req,
    output logic                  rsp_valid,
    output logic [LINE_IDX_W-1:0] rsp_tag,
    output logic [CL_DATA_W-1:0]  rsp_data,
    output rx_c1_t                wr_rsp,
    output logic                  almost_full
);

    integer                seed = SEED;
    logic [CL_ADDR_W-1:0]  pend_addr[$];
    logic [LINE_IDX_W-1:0] pend_tag[$];
    int                    pend_wait[$];
    int                    af_left;

    // Eight 64-bit words, each mixing the whole line address
    function automatic logic [CL_DATA_W-1:0] line_pattern(input logic [CL_ADDR_W-1:0] addr);
        logic [CL_DATA_W-1:0] line;
        for (int w = 0; w < 8; w++)
            line[w*64 +: 64] = {22'b0, addr} ^ (64'h9e37_79b9_7f4a_7c15 * (w + 1));
        return line;
    endfunction

    initial
    begin
        rsp_valid   = 1'b0;
        rsp_tag     = '0;
        rsp_data    = '0;
        wr_rsp      = '0;
        almost_full = 1'b0;
        af_left     = 0;
    end

    always @(posedge clk)
    begin
        logic                  next_valid;
        logic [LINE_IDX_W-1:0] next_tag;
        logic [CL_DATA_W-1:0]  next_data;
        rx_c1_t                next_wr;
        int                    start;
        int                    pick;
        next_valid = 1'b0;
        next_tag   = '0;
        next_data  = '0;
        next_wr    = '0;
        pick       = -1;
        if (!reset)
        begin
            if (rd_req.valid)
            begin
                pend_addr.push_back(rd_req.addr);
                pend_tag.push_back(rd_req.tag);
                pend_wait.push_back(1 + ($random(seed) & 7));
            end
            foreach (pend_wait[i])
                pend_wait[i] = pend_wait[i] - 1;
            // Random start of the scan gives out-of-order answers
            if (pend_wait.size() > 0)
            begin
                start = ($random(seed) & 32'h7fff_ffff) % pend_wait.size();
                for (int k = 0; k < pend_wait.size(); k++)
                    if (pick < 0 && pend_wait[(start + k) % pend_wait.size()] <= 0)
                        pick = (start + k) % pend_wait.size();
            end
            if (pick >= 0)
            begin
                next_valid = 1'b1;
                next_tag   = pend_tag[pick];
                next_data  = line_pattern(pend_addr[pick]);
                pend_addr.delete(pick);
                pend_tag.delete(pick);
                pend_wait.delete(pick);
            end
            // One write response per write seen
            next_wr.valid = wr_req.valid;
            next_wr.tag   = wr_req.tag;
            if (af_left > 0)
                af_left = af_left - 1;
            else if (($random(seed) & 63) == 0)
                af_left = 4 + ($random(seed) & 7);
        end
        #1;
        rsp_valid   = next_valid;
        rsp_tag     = next_tag;
        rsp_data    = next_data;
        wr_rsp      = next_wr;
        almost_full = (af_left > 0);
    end

endmodule
`default_nettype wire

// File: testbench/memcpy_tb.sv
`timescale 1ns/1ns
`default_nettype none
// ====================
// Testbench of the copy engine
// Runs are at most 256 lines, MMIO traffic only while the engine is idle
// Stops at the first error
// ====================
module memcpy_tb
    import memcpy_pkg::*;
;

    localparam int SEED    = 15597;
    localparam int N_RUN1  = 20;
    localparam int N_RUN2  = 37;
    // Worst case cycles per line plus a fixed margin
    localparam int WATCHDOG_NS = ((N_RUN1 + N_RUN2) * 40 + 2000) * 10;

    logic      clk = 1'b0;
    logic      reset;
    rx_c0_t    mmio_in;
    rx_c0_t    rx_c0;
    rx_c1_t    rx_c1;
    logic      tx_almost_full;
    rd_req_t   rd_req;
    wr_req_t   wr_req;
    mmio_rsp_t mmio_rsp;
    logic                  host_valid;
    logic [LINE_IDX_W-1:0] host_tag;
    logic [CL_DATA_W-1:0]  host_data;

    // Run parameters, written by the stimulus only
    logic [CL_ADDR_W-1:0]   run_src;
    logic [CL_ADDR_W-1:0]   run_dst;
    logic [CL_ADDR_W-1:0]   run_status;
    int                     run_n;
    int                     run_thr;
    int                     run_id = 0;
    int                     run_base = 0;
    int                     read_base = 0;
    logic                   expect_idle = 1'b0;
    logic [MMIO_DATA_W-1:0] exp_rd_data = '0;
    // Bookkeeping, written by the checker only
    logic                   prev_rd = 1'b0;
    logic [8:0]             prev_tid = '0;
    logic [MMIO_DATA_W-1:0] prev_exp = '0;
    int                     inflight = 0;
    int                     af_run = 0;
    int                     reads_seen = 0;
    int                     copy_writes = 0;
    int                     status_writes = 0;
    int                     written_run[256];

    always #5 clk = ~clk;

    memcpy memcpy_i (
        .clk            (clk),
        .reset          (reset),
        .rx_c0          (rx_c0),
        .rx_c1          (rx_c1),
        .tx_almost_full (tx_almost_full),
        .rd_req         (rd_req),
        .wr_req         (wr_req),
        .mmio_rsp       (mmio_rsp)
    );

    host_model #(.SEED(SEED)) host_model_i (
        .clk         (clk),
        .reset       (reset),
        .rd_req      (rd_req),
        .wr_req      (wr_req),
        .rsp_valid   (host_valid),
        .rsp_tag     (host_tag),
        .rsp_data    (host_data),
        .wr_rsp      (rx_c1),
        .almost_full (tx_almost_full)
    );

    // MMIO strobes own the shared channel, otherwise it carries read data
    always_comb
    begin
        rx_c0 = mmio_in;
        if (!mmio_in.mmio_rd && !mmio_in.mmio_wr)
        begin
            rx_c0.rsp_valid          = host_valid;
            rx_c0.hdr.rsp.rsvd       = '0;
            rx_c0.hdr.rsp.resp_type  = RSP_RDLINE;
            rx_c0.hdr.rsp.mdata      = host_tag;
            rx_c0.data               = host_data;
        end
    end

    function automatic logic [CL_DATA_W-1:0] expected_line(input logic [CL_ADDR_W-1:0] addr);
        logic [CL_DATA_W-1:0] line;
        for (int w = 0; w < 8; w++)
            line[w*64 +: 64] = {22'b0, addr} ^ (64'h9e37_79b9_7f4a_7c15 * (w + 1));
        return line;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [CL_DATA_W-1:0] exp,
                            input logic [CL_DATA_W-1:0] act);
        assert (exp === act)
        else
            stop_run($sformatf("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act));
    endtask

    // ====================
    // Checker, sees values as they were before the edge
    always @(posedge clk)
    begin
        logic [CL_ADDR_W-1:0] idx;
        if (!reset)
        begin
            prev_rd  <= rx_c0.mmio_rd;
            prev_tid <= rx_c0.hdr.mmio.tid;
            prev_exp <= exp_rd_data;
            af_run   <= tx_almost_full ? af_run + 1 : 0;
            // Response exactly one cycle after its read
            check_eq("mmio_rsp.valid", prev_rd, mmio_rsp.valid);
            if (mmio_rsp.valid)
            begin
                check_eq("mmio_rsp.tid", prev_tid, mmio_rsp.tid);
                check_eq("mmio_rsp.data", prev_exp, mmio_rsp.data);
            end
            if (rd_req.valid)
            begin
                assert (!expect_idle)
                else
                    stop_run("Read request issued after a start that should be rejected");
                assert (!(tx_almost_full && af_run >= 3))
                else
                    stop_run("Read request issued while almost-full was high too long");
                assert (inflight + 1 <= run_thr + 2)
                else
                    stop_run("Lines in flight exceed the threshold plus pipeline depth");
                // Reads leave in line order
                check_eq("rd_req.tag", reads_seen - read_base, rd_req.tag);
                check_eq("rd_req.addr", run_src + CL_ADDR_W'(reads_seen - read_base),
                         rd_req.addr);
                reads_seen <= reads_seen + 1;
            end
            // Status write response arrives with nothing in flight
            if (rd_req.valid && !(rx_c1.valid && inflight > 0))
                inflight <= inflight + 1;
            else if (!rd_req.valid && rx_c1.valid && inflight > 0)
                inflight <= inflight - 1;
            if (wr_req.valid)
            begin
                assert (!expect_idle)
                else
                    stop_run("Write request issued after a start that should be rejected");
            end
            if (wr_req.valid && wr_req.addr == run_status)
            begin
                check_eq("status bit 0", 1'b1, wr_req.data[0]);
                check_eq("status lines read", 32'(run_n), wr_req.data[159:128]);
                check_eq("status write responses", 32'(run_n), wr_req.data[191:160]);
                check_eq("status unused bits", '0,
                         {wr_req.data[CL_DATA_W-1:192], wr_req.data[63:1]});
                check_eq("read requests", run_n, reads_seen - read_base);
                check_eq("copy writes", run_n, copy_writes - run_base);
                assert (wr_req.data[127:64] != '0)
                else
                    stop_run("Status line shows a zero cycle count");
                status_writes <= status_writes + 1;
            end
            else if (wr_req.valid)
            begin
                idx = wr_req.addr - run_dst;
                assert (idx < CL_ADDR_W'(run_n) && written_run[idx[7:0]] != run_id)
                else
                    stop_run("Line write outside the destination or written twice");
                check_eq("wr_req.tag", idx, wr_req.tag);
                check_eq("wr_req.data", expected_line(run_src + idx), wr_req.data);
                written_run[idx[7:0]] <= run_id;
                copy_writes <= copy_writes + 1;
            end
        end
    end

    // ====================
    // Stimulus tasks, each returns 1 ns after a rising edge
    task automatic mmio_write(input logic [MMIO_ADDR_W-1:0] addr,
                              input logic [MMIO_DATA_W-1:0] value);
        mmio_in                  = '0;
        mmio_in.mmio_wr          = 1'b1;
        mmio_in.hdr.mmio.address = addr;
        mmio_in.data[63:0]       = value;
        @(posedge clk);
        #1;
        mmio_in = '0;
    endtask

    task automatic mmio_read(input logic [MMIO_ADDR_W-1:0] addr, input logic [8:0] tid,
                             input logic [MMIO_DATA_W-1:0] exp);
        exp_rd_data              = exp;
        mmio_in                  = '0;
        mmio_in.mmio_rd          = 1'b1;
        mmio_in.hdr.mmio.address = addr;
        mmio_in.hdr.mmio.tid     = tid;
        @(posedge clk);
        #1;
        mmio_in = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic copy_run(input logic [CL_ADDR_W-1:0] src, input logic [CL_ADDR_W-1:0] dst,
                            input logic [CL_ADDR_W-1:0] status, input int n, input int thr);
        int done_before;
        run_src    = src;
        run_dst    = dst;
        run_status = status;
        run_n      = n;
        run_thr    = thr;
        run_id     = run_id + 1;
        run_base   = copy_writes;
        read_base  = reads_seen;
        mmio_write(CSR_SRC_ADDR, 64'(src));
        mmio_write(CSR_DST_ADDR, 64'(dst));
        mmio_write(CSR_STATUS_ADDR, 64'(status));
        mmio_write(CSR_NUM_LINES, 64'(n));
        mmio_write(CSR_WR_THRESHOLD, 64'(thr));
        // Configuration reads back unchanged
        mmio_read(CSR_SRC_ADDR, 9'd10, 64'(src));
        mmio_read(CSR_DST_ADDR, 9'd11, 64'(dst));
        mmio_read(CSR_STATUS_ADDR, 9'd12, 64'(status));
        mmio_read(CSR_NUM_LINES, 9'd13, 64'(n));
        mmio_read(CSR_WR_THRESHOLD, 9'd14, 64'(thr));
        done_before = status_writes;
        mmio_write(CSR_CTL, 64'd1);
        wait (status_writes == done_before + 1);
        repeat (20) @(posedge clk);
        #1;
    endtask

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        stop_run("Timeout, the copy runs did not finish in time");
    end

    initial
    begin
        reset      = 1'b1;
        mmio_in    = '0;
        run_src    = '0;
        run_dst    = '0;
        run_status = '1;
        run_n      = 0;
        run_thr    = int'(DEFAULT_WR_THRESHOLD);
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        mmio_read(CSR_DFH, 9'd1, DFH_VALUE);
        mmio_read(CSR_ID_L, 9'd2, AFU_ID[63:0]);
        mmio_read(CSR_ID_H, 9'd3, AFU_ID[127:64]);
        // Addresses set but line count still 0, so this start must do nothing
        mmio_write(CSR_SRC_ADDR, 64'h100);
        mmio_write(CSR_DST_ADDR, 64'h2000);
        expect_idle = 1'b1;
        mmio_write(CSR_CTL, 64'd1);
        repeat (50) @(posedge clk);
        #1;
        expect_idle = 1'b0;
        copy_run(42'h100, 42'h2000, 42'h3000, N_RUN1, 4);
        copy_run(42'h500, 42'h4000, 42'h5000, N_RUN2, 64);
        $display("all tests passed");
        $finish;
    end

endmodule
`default_nettype wire

// File: memcpy.f
logic/memcpy_pkg.sv
logic/mmio_csr.sv
logic/copy_control.sv
logic/line_writer.sv
logic/memcpy.sv
testbench/host_model.sv
testbench/memcpy_tb.sv

// File: Makefile
# Verilator build of the copy engine testbench

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f memcpy.f \
		--top-module memcpy_tb -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vmemcpy_tb | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
